// File: design/bridge_defines.svh
/*
 * bus widths shared by the bridge package and the RTL
 */
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// byte addressed, one 32-bit word per beat
`define BRIDGE_ADDR_W 32
`define BRIDGE_DATA_W 32

// one strobe per byte lane
`define BRIDGE_STRB_W 4

`endif

// File: design/bridge_pkg.sv
/*
 * enums for port and arbiter states and data opcodes
 * packed structs for cpu requests, port-to-arbiter requests, axi payloads
 */
`include "bridge_defines.svh"

package bridge_pkg;

    typedef enum logic [2:0] {
        MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic [1:0] {PORT_IDLE, PORT_WAIT, PORT_DONE} port_state_e;

    typedef enum logic [2:0] {ARB_IDLE, ARB_AR, ARB_R, ARB_AW_W, ARB_B} arb_state_e;

    typedef struct packed {
        logic                      valid;  // one-cycle strobe
        logic [`BRIDGE_ADDR_W-1:0] addr;
    } ifetch_req_t;

    typedef struct packed {
        logic                      valid;
        mem_op_e                   op;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [`BRIDGE_DATA_W-1:0] wdata;  // unshifted, low bits hold the value
    } data_req_t;

    typedef struct packed {
        logic                      valid;  // level until grant_done
        logic [`BRIDGE_ADDR_W-1:0] addr;   // word aligned
        logic [2:0]                size;
    } bus_rd_req_t;

    typedef struct packed {
        logic                      valid;
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [2:0]                size;
        logic [`BRIDGE_DATA_W-1:0] data;   // already in its lanes
        logic [`BRIDGE_STRB_W-1:0] strb;
    } bus_wr_req_t;

    typedef struct packed {
        logic [`BRIDGE_ADDR_W-1:0] addr;
        logic [2:0]                size;
    } axi_addr_t;

    typedef struct packed {
        logic [`BRIDGE_DATA_W-1:0] data;
        logic [`BRIDGE_STRB_W-1:0] strb;
    } axi_wdata_t;

endpackage

// File: design/ifetch_port.sv
/*
 * instruction fetch port
 * holds one word read and hands back the word with a done pulse
 */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module ifetch_port import bridge_pkg::*; (
    input  logic                      aclk,
    input  logic                      rst,
    input  ifetch_req_t               i_req,
    output logic                      i_busy,
    output logic                      i_done,
    output logic [`BRIDGE_DATA_W-1:0] i_rdata,
    output bus_rd_req_t               rd_req,
    input  logic                      grant_done,
    input  logic [`BRIDGE_DATA_W-1:0] bus_rdata
);
    port_state_e               state;
    logic [`BRIDGE_ADDR_W-1:0] addr_q;
    logic [`BRIDGE_DATA_W-1:0] rdata_q;
    logic                      accept;

    assign accept = i_req.valid && (state != PORT_WAIT);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= PORT_IDLE;
        end else begin
            case (state)
                PORT_WAIT: if (grant_done) state <= PORT_DONE;
                // done cycle can take the next strobe straight away
                default:   state <= accept ? PORT_WAIT : PORT_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) addr_q <= i_req.addr;
        if (state == PORT_WAIT && grant_done) rdata_q <= bus_rdata;
    end

    assign i_busy  = (state == PORT_WAIT);
    assign i_done  = (state == PORT_DONE);
    assign i_rdata = rdata_q;

    // always a full word
    assign rd_req.valid = (state == PORT_WAIT);
    assign rd_req.addr  = addr_q;
    assign rd_req.size  = 3'd2;

    // fetch addresses come from a pc, never misaligned
    a_fetch_aligned: assert property (@(posedge aclk) disable iff (rst)
        accept |-> i_req.addr[1:0] == 2'b00);

endmodule

// File: design/data_port.sv
/*
 * data port for loads and stores of byte, half and word
 * builds lane-shifted write data and strobes, extends load results
 */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module data_port import bridge_pkg::*; (
    input  logic                      aclk,
    input  logic                      rst,
    input  data_req_t                 d_req,
    output logic                      d_busy,
    output logic                      d_done,
    output logic [`BRIDGE_DATA_W-1:0] d_rdata,
    output bus_rd_req_t               rd_req,
    output bus_wr_req_t               wr_req,
    input  logic                      grant_done,
    input  logic [`BRIDGE_DATA_W-1:0] bus_rdata
);
    port_state_e               state;
    mem_op_e                   op_q;
    logic [`BRIDGE_ADDR_W-1:0] addr_q;
    logic [`BRIDGE_DATA_W-1:0] wdata_q;
    logic [`BRIDGE_DATA_W-1:0] rdata_q;
    logic                      accept;
    logic                      is_store;
    logic [2:0]                size;
    logic [`BRIDGE_DATA_W-1:0] lane_word;  // returned word shifted down to lane 0
    logic [`BRIDGE_DATA_W-1:0] load_val;

    // axi size code from the opcode
    function automatic logic [2:0] op_size(input mem_op_e op);
        case (op)
            MEM_LB, MEM_LBU, MEM_SB: return 3'd0;
            MEM_LH, MEM_LHU, MEM_SH: return 3'd1;
            default:                 return 3'd2;
        endcase
    endfunction

    assign accept   = d_req.valid && (state != PORT_WAIT);
    assign is_store = op_q inside {MEM_SB, MEM_SH, MEM_SW};
    assign size     = op_size(op_q);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= PORT_IDLE;
        end else begin
            case (state)
                PORT_WAIT: if (grant_done) state <= PORT_DONE;
                default:   state <= accept ? PORT_WAIT : PORT_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            op_q    <= d_req.op;
            addr_q  <= d_req.addr;
            wdata_q <= d_req.wdata;
        end
        if (state == PORT_WAIT && grant_done) rdata_q <= load_val;
    end

    // loads read the whole word, the lane is picked here
    assign lane_word = bus_rdata >> {addr_q[1:0], 3'b000};

    always_comb begin
        case (op_q)
            MEM_LB:  load_val = {{24{lane_word[7]}}, lane_word[7:0]};
            MEM_LBU: load_val = {24'd0, lane_word[7:0]};
            MEM_LH:  load_val = {{16{lane_word[15]}}, lane_word[15:0]};
            MEM_LHU: load_val = {16'd0, lane_word[15:0]};
            default: load_val = bus_rdata;
        endcase
    end

    assign d_busy  = (state == PORT_WAIT);
    assign d_done  = (state == PORT_DONE);
    assign d_rdata = rdata_q;

    assign rd_req.valid = (state == PORT_WAIT) && !is_store;
    assign rd_req.addr  = {addr_q[`BRIDGE_ADDR_W-1:2], 2'b00};
    assign rd_req.size  = size;

    // writes keep the byte address, strobes mark the lanes
    assign wr_req.valid = (state == PORT_WAIT) && is_store;
    assign wr_req.addr  = addr_q;
    assign wr_req.size  = size;
    assign wr_req.data  = wdata_q << {addr_q[1:0], 3'b000};

    always_comb begin
        case (op_q)
            MEM_SB:  wr_req.strb = 4'b0001 << addr_q[1:0];
            MEM_SH:  wr_req.strb = addr_q[1] ? 4'b1100 : 4'b0011;
            default: wr_req.strb = 4'b1111;
        endcase
    end

    a_data_aligned: assert property (@(posedge aclk) disable iff (rst)
        accept |-> (!(d_req.op inside {MEM_LH, MEM_LHU, MEM_SH}) || !d_req.addr[0])
               && (!(d_req.op inside {MEM_LW, MEM_SW}) || d_req.addr[1:0] == 2'b00));

endmodule

// File: design/axi_arbiter.sv
/*
 * shares one single-beat axi master between the fetch and data ports
 * alternating priority on ties and one transaction in flight
 */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module axi_arbiter import bridge_pkg::*; (
    input  logic                      aclk,
    input  logic                      rst,
    input  bus_rd_req_t               i_rd_req,
    input  bus_rd_req_t               d_rd_req,
    input  bus_wr_req_t               d_wr_req,
    output logic                      i_grant_done,
    output logic                      d_grant_done,
    output logic [`BRIDGE_DATA_W-1:0] bus_rdata,
    output axi_addr_t                 ar,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [`BRIDGE_DATA_W-1:0] rdata,
    input  logic                      rvalid,
    output logic                      rready,
    output axi_addr_t                 aw,
    output logic                      awvalid,
    input  logic                      awready,
    output axi_wdata_t                w,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready
);
    arb_state_e state;
    logic       last_was_data;  // set after reset so fetch wins the first tie
    logic       grant_data;     // current grant belongs to the data port
    logic       awvalid_q;
    logic       wvalid_q;
    axi_addr_t  ar_q;
    axi_addr_t  aw_q;
    axi_wdata_t w_q;
    logic       i_want;
    logic       d_want;
    logic       pick_i;
    logic       r_end;
    logic       b_end;

    assign i_want = i_rd_req.valid;
    assign d_want = d_rd_req.valid || d_wr_req.valid;
    assign pick_i = i_want && (!d_want || last_was_data);

    always_ff @(posedge aclk) begin
        if (rst) begin
            state         <= ARB_IDLE;
            last_was_data <= 1'b1;
            grant_data    <= 1'b0;
            awvalid_q     <= 1'b0;
            wvalid_q      <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (pick_i) begin
                        grant_data    <= 1'b0;
                        last_was_data <= 1'b0;
                        state         <= ARB_AR;
                    end else if (d_want) begin
                        grant_data    <= 1'b1;
                        last_was_data <= 1'b1;
                        if (d_wr_req.valid) begin
                            awvalid_q <= 1'b1;  // aw and w go up together
                            wvalid_q  <= 1'b1;
                            state     <= ARB_AW_W;
                        end else begin
                            state <= ARB_AR;
                        end
                    end
                end
                ARB_AR: if (arready) state <= ARB_R;
                ARB_R:  if (rvalid) state <= ARB_IDLE;
                ARB_AW_W: begin
                    if (awready) awvalid_q <= 1'b0;
                    if (wready) wvalid_q <= 1'b0;
                    // both channels accepted now or earlier
                    if ((awready || !awvalid_q) && (wready || !wvalid_q)) state <= ARB_B;
                end
                ARB_B:   if (bvalid) state <= ARB_IDLE;
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // payloads follow the requests while idle and hold once granted
    always_ff @(posedge aclk) begin
        if (state == ARB_IDLE) begin
            if (pick_i) begin
                ar_q.addr <= i_rd_req.addr;
                ar_q.size <= i_rd_req.size;
            end else begin
                ar_q.addr <= d_rd_req.addr;
                ar_q.size <= d_rd_req.size;
            end
            aw_q.addr <= d_wr_req.addr;
            aw_q.size <= d_wr_req.size;
            w_q.data  <= d_wr_req.data;
            w_q.strb  <= d_wr_req.strb;
        end
    end

    assign ar      = ar_q;
    assign arvalid = (state == ARB_AR);
    assign rready  = (state == ARB_R);
    assign aw      = aw_q;
    assign awvalid = awvalid_q;
    assign w       = w_q;
    assign wvalid  = wvalid_q;
    assign bready  = (state == ARB_B);

    assign r_end        = (state == ARB_R) && rvalid;
    assign b_end        = (state == ARB_B) && bvalid;
    assign i_grant_done = r_end && !grant_data;
    assign d_grant_done = (r_end && grant_data) || b_end;
    assign bus_rdata    = rdata;  // sampled by the port on its grant pulse

    a_ar_hold: assert property (@(posedge aclk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(ar));

    a_one_done: assert property (@(posedge aclk) disable iff (rst)
        !(i_grant_done && d_grant_done));

    // r phase opens on an ar accept and lasts until the r beat
    a_rready_in_r: assert property (@(posedge aclk) disable iff (rst)
        rready |-> $past(arvalid && arready) || $past(rready && !rvalid));

endmodule

// File: design/mem_bridge_top.sv
/*
 * memory bridge top, fetch port and data port sharing one axi bus
 */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module mem_bridge_top import bridge_pkg::*; (
    input  logic                      aclk,
    input  logic                      rst,
    input  ifetch_req_t               i_req,
    output logic                      i_busy,
    output logic                      i_done,
    output logic [`BRIDGE_DATA_W-1:0] i_rdata,
    input  data_req_t                 d_req,
    output logic                      d_busy,
    output logic                      d_done,
    output logic [`BRIDGE_DATA_W-1:0] d_rdata,
    output axi_addr_t                 ar,
    output logic                      arvalid,
    input  logic                      arready,
    input  logic [`BRIDGE_DATA_W-1:0] rdata,
    input  logic                      rvalid,
    output logic                      rready,
    output axi_addr_t                 aw,
    output logic                      awvalid,
    input  logic                      awready,
    output axi_wdata_t                w,
    output logic                      wvalid,
    input  logic                      wready,
    input  logic                      bvalid,
    output logic                      bready
);
    bus_rd_req_t               i_rd_req;
    bus_rd_req_t               d_rd_req;
    bus_wr_req_t               d_wr_req;
    logic                      i_grant_done;
    logic                      d_grant_done;
    logic [`BRIDGE_DATA_W-1:0] bus_rdata;  // shared by both ports

    ifetch_port u_ifetch_port (
        .aclk       (aclk),
        .rst        (rst),
        .i_req      (i_req),
        .i_busy     (i_busy),
        .i_done     (i_done),
        .i_rdata    (i_rdata),
        .rd_req     (i_rd_req),
        .grant_done (i_grant_done),
        .bus_rdata  (bus_rdata)
    );

    data_port u_data_port (
        .aclk       (aclk),
        .rst        (rst),
        .d_req      (d_req),
        .d_busy     (d_busy),
        .d_done     (d_done),
        .d_rdata    (d_rdata),
        .rd_req     (d_rd_req),
        .wr_req     (d_wr_req),
        .grant_done (d_grant_done),
        .bus_rdata  (bus_rdata)
    );

    axi_arbiter u_axi_arbiter (
        .aclk         (aclk),
        .rst          (rst),
        .i_rd_req     (i_rd_req),
        .d_rd_req     (d_rd_req),
        .d_wr_req     (d_wr_req),
        .i_grant_done (i_grant_done),
        .d_grant_done (d_grant_done),
        .bus_rdata    (bus_rdata),
        .ar           (ar),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rvalid       (rvalid),
        .rready       (rready),
        .aw           (aw),
        .awvalid      (awvalid),
        .awready      (awready),
        .w            (w),
        .wvalid       (wvalid),
        .wready       (wready),
        .bvalid       (bvalid),
        .bready       (bready)
    );

endmodule

// File: tests/bridge_checker.sv
/*
 * memory bridge checker with shadow memory and expected load and fetch data
 * address, size, strobe, ar hold and reset level checks, error count
 */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module bridge_checker import bridge_pkg::*; (
    input  logic                      aclk,
    input  logic                      rst,
    input  ifetch_req_t               i_req,
    input  logic                      i_busy,
    input  logic                      i_done,
    input  logic [`BRIDGE_DATA_W-1:0] i_rdata,
    input  data_req_t                 d_req,
    input  logic                      d_busy,
    input  logic                      d_done,
    input  logic [`BRIDGE_DATA_W-1:0] d_rdata,
    input  axi_addr_t                 ar,
    input  logic                      arvalid,
    input  logic                      arready,
    input  logic                      rready,
    input  axi_addr_t                 aw,
    input  logic                      awvalid,
    input  logic                      awready,
    input  axi_wdata_t                w,
    input  logic                      wvalid,
    input  logic                      wready,
    input  logic                      bready,
    output int                        err_count
);
    logic [31:0] shadow [logic [31:0]];  // word address -> stored contents
    logic        rst_q = 1'b0;
    logic        i_pend = 1'b0;
    logic        d_pend = 1'b0;
    logic        d_load = 1'b0;
    logic        ar_wait = 1'b0;  // arvalid was up without arready
    logic [31:0] i_exp;
    logic [31:0] d_exp;
    logic [3:0]  strb_exp;
    axi_addr_t   ar_prev;
    axi_addr_t   i_ar_exp;    // ar expected for the pending fetch
    axi_addr_t   d_addr_exp;  // ar or aw expected for the pending data request

    initial err_count = 0;

    // contents of memory that was never written
    function automatic logic [31:0] initial_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        logic [31:0] key;
        key = {a[31:2], 2'b00};
        return shadow.exists(key) ? shadow[key] : initial_word(key);
    endfunction

    // axi size code is log2 of the access width in bytes
    function automatic logic [2:0] access_size(input mem_op_e op);
        if (op inside {MEM_LB, MEM_LBU, MEM_SB}) return 3'd0;
        if (op inside {MEM_LH, MEM_LHU, MEM_SH}) return 3'd1;
        return 3'd2;
    endfunction

    function automatic logic [3:0] lane_strb(input mem_op_e op, input logic [1:0] off);
        logic [3:0] s;
        s = 4'b0000;
        case (op)
            MEM_SB: s[off] = 1'b1;
            MEM_SH: begin
                s[off]        = 1'b1;
                s[off + 2'd1] = 1'b1;  // halves sit on even offsets
            end
            default: s = 4'b1111;
        endcase
        return s;
    endfunction

    function automatic logic [31:0] merge_store(input logic [31:0] old, input logic [3:0] strb,
                                                input logic [1:0] off, input logic [31:0] wdata);
        logic [31:0] shifted;
        logic [31:0] res;
        shifted = wdata << (8 * off);
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) res[8*b +: 8] = shifted[8*b +: 8];
        end
        return res;
    endfunction

    // reference for load results
    function automatic logic [31:0] load_result(input mem_op_e op, input logic [1:0] off,
                                                input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (op)
            MEM_LB:  return {{24{b[7]}}, b};
            MEM_LBU: return {24'h0, b};
            MEM_LH:  return {{16{h[15]}}, h};
            MEM_LHU: return {16'h0, h};
            default: return word;
        endcase
    endfunction

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        if (exp !== act) begin
            err_count++;
            $display("Error: %s expected 0x%08h actual 0x%08h", name, exp, act);
        end
    endtask

    task automatic expect_low(input string name, input logic value);
        if (value !== 1'b0) begin
            err_count++;
            $display("Error: %s expected 0x0 actual 0x%0h during reset", name, value);
        end
    endtask

    task automatic flag_failure(input string msg);
        err_count++;
        $display("Failure at %0t ns: %s", $time, msg);
    endtask

    always @(posedge aclk) begin : compare
        logic [31:0] key;
        rst_q <= rst;
        if (rst_q) begin  // outputs settled from a reset edge
            expect_low("arvalid", arvalid);
            expect_low("awvalid", awvalid);
            expect_low("wvalid", wvalid);
            expect_low("rready", rready);
            expect_low("bready", bready);
            expect_low("i_busy", i_busy);
            expect_low("d_busy", d_busy);
            expect_low("i_done", i_done);
            expect_low("d_done", d_done);
        end
        if (rst) begin
            i_pend  = 1'b0;
            d_pend  = 1'b0;
            ar_wait = 1'b0;
        end else begin
            if (ar_wait && (arvalid !== 1'b1 || ar !== ar_prev))
                flag_failure("arvalid dropped or ar changed before arready");
            ar_wait = arvalid && !arready;
            ar_prev = ar;

            // fetch and data addresses sit in separate regions
            if (arvalid && arready) begin
                if (i_pend && ar.addr === i_ar_exp.addr) begin
                    compare_value("ar.size", {29'h0, i_ar_exp.size}, {29'h0, ar.size});
                end else if (d_pend && d_load) begin
                    compare_value("ar.addr", d_addr_exp.addr, ar.addr);
                    compare_value("ar.size", {29'h0, d_addr_exp.size}, {29'h0, ar.size});
                end else begin
                    flag_failure("read address accepted with no read pending");
                end
            end
            if (awvalid && awready) begin
                if (d_pend && !d_load) begin
                    compare_value("aw.addr", d_addr_exp.addr, aw.addr);
                    compare_value("aw.size", {29'h0, d_addr_exp.size}, {29'h0, aw.size});
                end else begin
                    flag_failure("write address accepted with no store pending");
                end
            end

            if (i_done) begin
                if (!i_pend) flag_failure("i_done pulse with no fetch pending");
                else compare_value("i_rdata", i_exp, i_rdata);
                i_pend = 1'b0;
            end
            if (d_done) begin
                if (!d_pend) flag_failure("d_done pulse with no data request pending");
                else if (d_load) compare_value("d_rdata", d_exp, d_rdata);
                d_pend = 1'b0;
            end
            if (wvalid && wready)
                compare_value("w.strb", {28'h0, strb_exp}, {28'h0, w.strb});

            // new requests come after the done of the previous one
            if (i_req.valid && !i_busy) begin
                i_pend        = 1'b1;
                i_exp         = shadow_word(i_req.addr);
                i_ar_exp.addr = i_req.addr;
                i_ar_exp.size = 3'd2;
            end
            if (d_req.valid && !d_busy) begin
                d_pend          = 1'b1;
                d_load          = !(d_req.op inside {MEM_SB, MEM_SH, MEM_SW});
                d_addr_exp.size = access_size(d_req.op);
                if (d_load) begin
                    d_addr_exp.addr = {d_req.addr[31:2], 2'b00};  // reads fetch the whole word
                    d_exp = load_result(d_req.op, d_req.addr[1:0], shadow_word(d_req.addr));
                end else begin
                    d_addr_exp.addr = d_req.addr;
                    strb_exp        = lane_strb(d_req.op, d_req.addr[1:0]);
                    key             = {d_req.addr[31:2], 2'b00};
                    shadow[key]     = merge_store(shadow_word(key), strb_exp, d_req.addr[1:0],
                                                  d_req.wdata);
                end
            end
        end
    end

endmodule

// File: tests/tb_mem_bridge.sv
/*
 * testbench top with clock, reset and an axi slave memory with random ready delays
 * directed and random fetch and data traffic and the closing report
 */
`timescale 1ns/1ps
`include "bridge_defines.svh"

module tb_mem_bridge import bridge_pkg::*; ();
    localparam int          TIMEOUT = 200;            // cycles per request
    localparam logic [31:0] IBASE   = 32'h0001_0000;  // fetch region that stores never reach

    logic                      aclk;
    logic                      rst;
    ifetch_req_t               i_req;
    logic                      i_busy;
    logic                      i_done;
    logic [`BRIDGE_DATA_W-1:0] i_rdata;
    data_req_t                 d_req;
    logic                      d_busy;
    logic                      d_done;
    logic [`BRIDGE_DATA_W-1:0] d_rdata;
    axi_addr_t                 ar;
    axi_addr_t                 aw;
    axi_wdata_t                w;
    logic                      arvalid;
    logic                      rready;
    logic                      awvalid;
    logic                      wvalid;
    logic                      bready;
    logic                      arready = 1'b0;
    logic                      rvalid  = 1'b0;
    logic [`BRIDGE_DATA_W-1:0] rdata   = '0;
    logic                      awready = 1'b0;
    logic                      wready  = 1'b0;
    logic                      bvalid  = 1'b0;
    int                        seed;
    int                        err_count;
    int                        timeouts;

    // slave model state
    logic [31:0] mem [logic [31:0]];
    logic [1:0]  ar_dly, r_dly, aw_dly, w_dly, b_dly;
    logic        rd_pend, aw_got, w_got, b_pend;
    logic [31:0] rd_addr, wr_addr;
    axi_wdata_t  wr_beat;

    mem_bridge_top dut_i (.*);
    bridge_checker chk_i (.*);

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    function automatic logic [31:0] fill_word(input logic [31:0] a);
        return (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        logic [31:0] key;
        key = {a[31:2], 2'b00};
        return mem.exists(key) ? mem[key] : fill_word(key);
    endfunction

    task automatic write_word(input logic [31:0] a, input axi_wdata_t beat);
        logic [31:0] word;
        word = read_word(a);
        for (int b = 0; b < 4; b++) begin
            if (beat.strb[b]) word[8*b +: 8] = beat.data[8*b +: 8];
        end
        mem[{a[31:2], 2'b00}] = word;
    endtask

    function automatic logic [1:0] rand_delay();
        int r;
        r = $random(seed);
        return r[1:0];
    endfunction

    // single-beat axi slave with every ready and response after 0 to 3 cycles
    always @(posedge aclk) begin
        if (rst) begin
            {arready, rvalid, awready, wready, bvalid} <= '0;
            {rd_pend, aw_got, w_got, b_pend} <= '0;
            ar_dly <= rand_delay();
            aw_dly <= rand_delay();
            w_dly  <= rand_delay();
        end else begin
            if (arvalid && arready) begin
                arready <= 1'b0;
                rd_addr <= ar.addr;
                rd_pend <= 1'b1;
                r_dly   <= rand_delay();
                ar_dly  <= rand_delay();
            end else if (arvalid) begin
                if (ar_dly == 2'd0) arready <= 1'b1;
                else ar_dly <= ar_dly - 2'd1;
            end
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                rd_pend <= 1'b0;
            end else if (rd_pend && !rvalid) begin
                if (r_dly == 2'd0) begin
                    rvalid <= 1'b1;
                    rdata  <= read_word(rd_addr);
                end else begin
                    r_dly <= r_dly - 2'd1;
                end
            end
            if (awvalid && awready) begin
                awready <= 1'b0;
                aw_got  <= 1'b1;
                wr_addr <= aw.addr;
                aw_dly  <= rand_delay();
            end else if (awvalid) begin
                if (aw_dly == 2'd0) awready <= 1'b1;
                else aw_dly <= aw_dly - 2'd1;
            end
            if (wvalid && wready) begin
                wready  <= 1'b0;
                w_got   <= 1'b1;
                wr_beat <= w;
                w_dly   <= rand_delay();
            end else if (wvalid) begin
                if (w_dly == 2'd0) wready <= 1'b1;
                else w_dly <= w_dly - 2'd1;
            end
            if (aw_got && w_got) begin  // commit once both halves are in
                write_word(wr_addr, wr_beat);
                aw_got <= 1'b0;
                w_got  <= 1'b0;
                b_pend <= 1'b1;
                b_dly  <= rand_delay();
            end
            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_pend <= 1'b0;
            end else if (b_pend && !bvalid) begin
                if (b_dly == 2'd0) bvalid <= 1'b1;
                else b_dly <= b_dly - 2'd1;
            end
        end
    end

    task automatic wait_done(input bit is_data, output bit seen);
        int n;
        n = 0;
        seen = 1'b0;
        while (!seen && n < TIMEOUT) begin
            @(posedge aclk);
            seen = is_data ? d_done : i_done;
            n++;
        end
    endtask

    task automatic fetch(input logic [31:0] a);
        bit seen;
        @(posedge aclk);
        i_req <= '{valid: 1'b1, addr: a};
        @(posedge aclk);
        i_req.valid <= 1'b0;  // one-cycle strobe
        wait_done(1'b0, seen);
        if (!seen) begin
            timeouts++;
            $display("Timeout: fetch from 0x%08h never completed", a);
        end
    endtask

    task automatic data_access(input mem_op_e op, input logic [31:0] a, input logic [31:0] wd);
        bit seen;
        @(posedge aclk);
        d_req <= '{valid: 1'b1, op: op, addr: a, wdata: wd};
        @(posedge aclk);
        d_req.valid <= 1'b0;
        wait_done(1'b1, seen);
        if (!seen) begin
            timeouts++;
            $display("Timeout: %s at 0x%08h never completed", op.name(), a);
        end
    endtask

    function automatic logic [31:0] rand_data_addr(input mem_op_e op);
        int          r;
        logic [31:0] a;
        r = $random(seed);
        a = {26'h0, r[5:0]};  // 16 words so stores and loads overlap
        if (op inside {MEM_LH, MEM_LHU, MEM_SH}) a[0] = 1'b0;
        if (op inside {MEM_LW, MEM_SW}) a[1:0] = 2'b00;
        return a;
    endfunction

    initial begin : stimulus
        int          r;
        mem_op_e     op;
        logic [31:0] da;
        logic [31:0] wd;
        seed     = 32'h883dd250;
        timeouts = 0;
        rst      = 1'b1;
        i_req    = '0;
        d_req    = '0;
        repeat (8) @(posedge aclk);
        rst <= 1'b0;

        for (int k = 0; k < 4; k++) fetch(IBASE + 32'(4 * k));
        data_access(MEM_SW, 32'h40, 32'hcafe_f00d);
        data_access(MEM_LW, 32'h40, 32'h0);
        for (int k = 0; k < 4; k++) data_access(MEM_SB, 32'h80 + k, 32'h5a + k);
        data_access(MEM_LW, 32'h80, 32'h0);
        data_access(MEM_SH, 32'h90, 32'h0000_8001);
        data_access(MEM_SH, 32'h92, 32'h0000_7ffe);
        data_access(MEM_LW, 32'h90, 32'h0);
        // bytes of 0xcafef00d and halves of 0x7ffe8001 cover both signs
        for (int k = 0; k < 4; k++) begin
            data_access(MEM_LB, 32'h40 + k, 32'h0);
            data_access(MEM_LBU, 32'h40 + k, 32'h0);
        end
        for (int k = 0; k < 4; k += 2) begin
            data_access(MEM_LH, 32'h90 + k, 32'h0);
            data_access(MEM_LHU, 32'h90 + k, 32'h0);
        end

        // both ports at once under random back-pressure
        for (int k = 0; k < 24; k++) begin
            @(negedge aclk);  // draw stimulus away from the slave's draws
            r  = $random(seed);
            op = mem_op_e'(r[2:0]);
            da = rand_data_addr(op);
            wd = $random(seed);
            fork
                fetch(IBASE + {24'h0, r[13:8], 2'b00});
                data_access(op, da, wd);
            join
        end

        repeat (4) @(posedge aclk);
        $display("Closing report: %0d check errors, %0d timeouts", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: mem_bridge_top.f
+incdir+design
design/bridge_pkg.sv
design/ifetch_port.sv
design/data_port.sv
design/axi_arbiter.sv
design/mem_bridge_top.sv
tests/bridge_checker.sv
tests/tb_mem_bridge.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_mem_bridge
FILELIST = mem_bridge_top.f

BUILD   = obj_dir
BIN     = $(BUILD)/V$(TOP)
SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(BUILD)
